/* ooo_backend.f */
+incdir+rtl
rtl/isa_pkg.sv
rtl/backend_pkg.sv
rtl/issue_stage.sv
rtl/alu_unit.sv
rtl/branch_unit.sv
rtl/result_buffer.sv
rtl/wb_arbiter.sv
rtl/reorder_buffer.sv
rtl/ooo_backend_top.sv
verif/tb_ooo_backend.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary -j 0 --top-module tb_ooo_backend -f ooo_backend.f -o sim_ooo_backend

sim_out="$(./obj_dir/sim_ooo_backend 2>&1 || true)"
printf '%s\n' "$sim_out"

if printf '%s\n' "$sim_out" | grep -qx "Done: no errors"; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

/* verif/tb_ooo_backend.sv */
`default_nettype none
`timescale 1ns/100ps

`include "ooo_backend_consts.svh"

module tb_ooo_backend;

    import isa_pkg::*;
    import backend_pkg::*;

    localparam int CREDIT_TIMEOUT = 100;
    localparam int DRAIN_TIMEOUT  = 200;

    // one table row
    // rnd bit 0 draws src_a and bit 1 draws src_b
    typedef struct packed {
        op_class_t               cls;
        alu_func_t               func;
        br_cond_t                cond;
        logic [`AREG_W-1:0]      rd;
        logic [`DATA_W-1:0]      a;
        logic [`DATA_W-1:0]      b;
        logic [`DATA_W-1:0]      pc;
        logic [`DATA_W-1:0]      imm;
        logic [1:0]              rnd;
        int                      gap;
    } stim_row_t;

    logic        clk;
    logic        rst_n;
    logic        op_valid;
    issue_op_t   op;
    logic        commit_valid;
    commit_rec_t commit_rec;
    logic        credit;

    stim_row_t   rows[$];
    commit_rec_t exp_q[$];
    rob_tag_t    next_tag;
    logic [31:0] lfsr_q;
    int          sent;
    int          commits;
    int          credit_pulses;
    int          stall_cycles;

    ooo_backend_top ooo_backend_top_inst (
        .clk_i          (clk),
        .rst_n_i        (rst_n),
        .op_valid_i     (op_valid),
        .op_i           (op),
        .commit_valid_o (commit_valid),
        .commit_o       (commit_rec),
        .credit_o       (credit)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ------------------------------------------------------------------------
    // checking and failure
    // ------------------------------------------------------------------------
    task automatic check_equal(input logic [127:0] got, input logic [127:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("[ERROR] %0d ns: %s, got %h expected %h", $time, what, got, exp);
            $display("Done: errors found");
            $fatal(1, "first mismatch");
        end
    endtask

    task automatic stop_with_failure(input string why);
        $display("%0d ns: %s", $time, why);
        $display("Done: errors found");
        $fatal(1, "run aborted");
    endtask

    // producer credits start full and drop per send and rise per pulse
    function automatic int credits_left();
        return `ROB_DEPTH - sent + credit_pulses;
    endfunction

    // ------------------------------------------------------------------------
    // random operands
    // ------------------------------------------------------------------------
    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic fb;
        fb = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], fb};
    endfunction

    // one lfsr step per bit taken
    task automatic draw_random(output logic [`DATA_W-1:0] value);
        value = '0;
        for (int k = 0; k < `DATA_W; k++) begin
            lfsr_q = lfsr_next(lfsr_q);
            value  = {value[`DATA_W-2:0], lfsr_q[0]};
        end
    endtask

    // ------------------------------------------------------------------------
    // reference model
    // ------------------------------------------------------------------------
    function automatic commit_rec_t model_commit(input stim_row_t row, input rob_tag_t tag);
        commit_rec_t rec;
        logic        taken;
        rec     = '0;
        rec.tag = tag;
        rec.rd  = row.rd;
        if (row.cls == OP_ALU) begin
            case (row.func)
                ALU_ADD: rec.value = row.a + row.b;
                ALU_SUB: rec.value = row.a - row.b;
                ALU_AND: rec.value = row.a & row.b;
                ALU_OR:  rec.value = row.a | row.b;
                ALU_XOR: rec.value = row.a ^ row.b;
                default: rec.value = '0;
            endcase
        end else begin
            // ltu compares unsigned
            if (row.cond == BR_EQ) begin
                taken = (row.a == row.b);
            end else begin
                taken = (row.a < row.b);
            end
            rec.value     = row.pc + 32'd4;
            rec.is_branch = 1'b1;
            rec.taken     = taken;
            rec.target    = taken ? (row.pc + row.imm) : (row.pc + 32'd4);
        end
        return rec;
    endfunction

    // ------------------------------------------------------------------------
    // stimulus table
    // ------------------------------------------------------------------------
    task automatic add_alu(input alu_func_t func, input logic [`AREG_W-1:0] rd,
                           input logic [`DATA_W-1:0] a, input logic [`DATA_W-1:0] b,
                           input logic [1:0] rnd, input int gap);
        rows.push_back('{OP_ALU, func, BR_EQ, rd, a, b, 32'h0, 32'h0, rnd, gap});
    endtask

    task automatic add_branch(input br_cond_t cond, input logic [`AREG_W-1:0] rd,
                              input logic [`DATA_W-1:0] a, input logic [`DATA_W-1:0] b,
                              input logic [`DATA_W-1:0] pc, input logic [`DATA_W-1:0] imm,
                              input logic [1:0] rnd, input int gap);
        rows.push_back('{OP_BRANCH, ALU_ADD, cond, rd, a, b, pc, imm, rnd, gap});
    endtask

    task automatic build_table();
        // spaced out alu ops with an underflowing sub
        add_alu(ALU_ADD, 5'd1, 32'd7, 32'd9, 2'b00, 3);
        add_alu(ALU_SUB, 5'd2, 32'd3, 32'd5, 2'b00, 2);
        add_alu(ALU_AND, 5'd3, 32'hff00ff00, 32'h0f0f0f0f, 2'b00, 2);
        // back to back from here on
        add_alu(ALU_OR, 5'd4, 32'h12340000, 32'h00005678, 2'b00, 0);
        add_alu(ALU_XOR, 5'd5, 32'haaaa5555, 32'hffff0000, 2'b00, 0);
        add_branch(BR_EQ, 5'd6, 32'd10, 32'd10, 32'h100, 32'h40, 2'b00, 0);
        add_branch(BR_EQ, 5'd7, 32'd10, 32'd11, 32'h104, 32'h40, 2'b00, 0);
        add_branch(BR_LTU, 5'd8, 32'h1, 32'hffffffff, 32'h108, 32'h20, 2'b00, 0);
        add_branch(BR_LTU, 5'd9, 32'hffffffff, 32'h1, 32'h10c, 32'h20, 2'b00, 0);
        add_alu(ALU_ADD, 5'd10, 32'hffffffff, 32'd2, 2'b00, 0);
        // backward target
        add_branch(BR_EQ, 5'd11, 32'd5, 32'd5, 32'h200, 32'hfffffff0, 2'b00, 0);
        add_alu(ALU_ADD, 5'd12, 32'd0, 32'd0, 2'b11, 0);
        add_alu(ALU_SUB, 5'd13, 32'd0, 32'd0, 2'b11, 0);
        add_branch(BR_LTU, 5'd14, 32'd0, 32'd0, 32'h300, 32'h80, 2'b11, 0);
        add_alu(ALU_XOR, 5'd15, 32'd0, 32'h0000ffff, 2'b01, 0);
        add_alu(ALU_AND, 5'd16, 32'hffff0000, 32'd0, 2'b10, 0);
        add_branch(BR_EQ, 5'd17, 32'd9, 32'd0, 32'h400, 32'h10, 2'b10, 0);
        add_alu(ALU_OR, 5'd18, 32'd0, 32'd0, 2'b11, 0);
        add_branch(BR_EQ, 5'd19, 32'd0, 32'd0, 32'h500, 32'h8, 2'b00, 0);
        add_alu(ALU_SUB, 5'd20, 32'd0, 32'd1, 2'b00, 0);
        add_alu(ALU_ADD, 5'd21, 32'd0, 32'd0, 2'b11, 0);
        add_branch(BR_LTU, 5'd22, 32'd0, 32'd0, 32'h600, 32'h4, 2'b11, 0);
        add_alu(ALU_XOR, 5'd23, 32'd0, 32'd0, 2'b11, 0);
        add_alu(ALU_ADD, 5'd24, 32'd0, 32'd0, 2'b01, 0);
        // ltu with equal operands is not taken
        add_branch(BR_LTU, 5'd25, 32'd3, 32'd3, 32'h700, 32'h10, 2'b00, 0);
        add_alu(ALU_AND, 5'd31, 32'd0, 32'd0, 2'b11, 0);
    endtask

    // ------------------------------------------------------------------------
    // producer task runs from 1 ns after a rising edge
    // ------------------------------------------------------------------------
    task automatic send_op(input stim_row_t row_in);
        stim_row_t row;
        int        waited;
        row    = row_in;
        waited = 0;
        repeat (row.gap) begin
            @(posedge clk);
            #1;
        end
        // hold off while out of credits
        while (credits_left() == 0) begin
            if (waited >= CREDIT_TIMEOUT) begin
                stop_with_failure("timeout waiting for a credit");
            end else begin
                @(posedge clk);
                #1;
                waited++;
                stall_cycles++;
            end
        end
        if (row.rnd[0]) begin
            draw_random(row.a);
        end
        if (row.rnd[1]) begin
            draw_random(row.b);
        end
        exp_q.push_back(model_commit(row, next_tag));
        next_tag    = next_tag + 1'b1;
        op.op_class = row.cls;
        op.func     = row.func;
        op.cond     = row.cond;
        op.rd       = row.rd;
        op.src_a    = row.a;
        op.src_b    = row.b;
        op.pc       = row.pc;
        op.imm      = row.imm;
        op_valid    = 1'b1;
        sent++;
        @(posedge clk);
        #1;
        op_valid = 1'b0;
    endtask

    // ------------------------------------------------------------------------
    // commit monitor sampling mid cycle
    // ------------------------------------------------------------------------
    initial begin
        forever begin
            @(negedge clk);
            // credit and commit share one registered pulse
            check_equal(128'(credit), 128'(commit_valid), "credit_o against commit_valid_o");
            if (!rst_n) begin
                check_equal(128'(commit_valid), 128'(0), "commit_valid_o during reset");
            end
            if (credit) begin
                credit_pulses++;
            end
            if (commit_valid) begin
                if (commits >= exp_q.size()) begin
                    stop_with_failure("commit seen with no operation outstanding");
                end else begin
                    check_equal(128'(commit_rec), 128'(exp_q[commits]), "commit record");
                    commits++;
                end
            end
        end
    end

    // ------------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------------
    initial begin
        int waited;
        rst_n         = 1'b0;
        op_valid      = 1'b0;
        op            = '0;
        next_tag      = '0;
        lfsr_q        = 32'hacc714c5;
        sent          = 0;
        commits       = 0;
        credit_pulses = 0;
        stall_cycles  = 0;
        waited        = 0;
        build_table();
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;
        foreach (rows[i]) begin
            send_op(rows[i]);
        end
        // all committed and every credit back
        while (commits != exp_q.size() || credits_left() != `ROB_DEPTH) begin
            if (waited >= DRAIN_TIMEOUT) begin
                stop_with_failure("timeout waiting for outstanding commits");
            end else begin
                @(posedge clk);
                #1;
                waited++;
            end
        end
        $display("info: %0d ops, %0d stall cycles", sent, stall_cycles);
        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire

/* rtl/ooo_backend_top.sv */
`default_nettype none
`timescale 1ns/100ps

module ooo_backend_top (
    input  wire logic                  clk_i,
    input  wire logic                  rst_n_i,
    input  wire logic                  op_valid_i,
    input  wire isa_pkg::issue_op_t    op_i,
    output logic                       commit_valid_o,
    output backend_pkg::commit_rec_t   commit_o,
    output logic                       credit_o
);

    import backend_pkg::*;

    // ------------------------------------------------------------------------
    // issue to units
    // ------------------------------------------------------------------------
    logic        alu_valid;
    alu_op_t     alu_op;
    logic        br_valid;
    br_op_t      br_op;
    logic        alloc_valid;

    // units to result buffers
    logic        alu_res_valid;
    alu_result_t alu_res;
    logic        br_res_valid;
    br_result_t  br_res;

    // buffer heads and pops
    logic        alu_head_valid;
    alu_result_t alu_head;
    logic        alu_pop;
    logic        br_head_valid;
    br_result_t  br_head;
    logic        br_pop;

    // writeback into the rob
    logic        wb_valid;
    wb_packet_t  wb_packet;

    issue_stage issue_stage_inst (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .op_valid_i    (op_valid_i),
        .op_i          (op_i),
        .alu_valid_o   (alu_valid),
        .alu_op_o      (alu_op),
        .br_valid_o    (br_valid),
        .br_op_o       (br_op),
        .alloc_valid_o (alloc_valid)
    );

    alu_unit alu_unit_inst (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .op_valid_i  (alu_valid),
        .op_i        (alu_op),
        .res_valid_o (alu_res_valid),
        .res_o       (alu_res)
    );

    branch_unit branch_unit_inst (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .op_valid_i  (br_valid),
        .op_i        (br_op),
        .res_valid_o (br_res_valid),
        .res_o       (br_res)
    );

    result_buffer #(.payload_t(alu_result_t)) alu_buffer_inst (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .push_i       (alu_res_valid),
        .push_data_i  (alu_res),
        .pop_i        (alu_pop),
        .head_valid_o (alu_head_valid),
        .head_o       (alu_head)
    );

    result_buffer #(.payload_t(br_result_t)) br_buffer_inst (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .push_i       (br_res_valid),
        .push_data_i  (br_res),
        .pop_i        (br_pop),
        .head_valid_o (br_head_valid),
        .head_o       (br_head)
    );

    wb_arbiter wb_arbiter_inst (
        .alu_valid_i (alu_head_valid),
        .alu_res_i   (alu_head),
        .alu_pop_o   (alu_pop),
        .br_valid_i  (br_head_valid),
        .br_res_i    (br_head),
        .br_pop_o    (br_pop),
        .wb_valid_o  (wb_valid),
        .wb_o        (wb_packet)
    );

    reorder_buffer reorder_buffer_inst (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .alloc_valid_i  (alloc_valid),
        .wb_valid_i     (wb_valid),
        .wb_i           (wb_packet),
        .commit_valid_o (commit_valid_o),
        .commit_o       (commit_o),
        .credit_o       (credit_o)
    );

endmodule

`default_nettype wire

/* rtl/reorder_buffer.sv */
`default_nettype none
`timescale 1ns/100ps

`include "ooo_backend_consts.svh"

module reorder_buffer (
    input  wire logic                      clk_i,
    input  wire logic                      rst_n_i,
    input  wire logic                      alloc_valid_i,
    input  wire logic                      wb_valid_i,
    input  wire backend_pkg::wb_packet_t   wb_i,
    output logic                           commit_valid_o,
    output backend_pkg::commit_rec_t       commit_o,
    output logic                           credit_o
);

    import backend_pkg::*;

    rob_tag_t              head_q;
    rob_tag_t              tail_q;
    logic [`ROB_DEPTH-1:0] busy_q;
    logic [`ROB_DEPTH-1:0] done_q;
    wb_packet_t            entry_q [`ROB_DEPTH];
    logic                  retire;

    // oldest entry finished
    assign retire = busy_q[head_q] && done_q[head_q];

    // one credit back per retired entry, same cycle as the record
    assign credit_o = commit_valid_o;

    // ------------------------------------------------------------------------
    // allocation, completion and in-order retire
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            head_q         <= '0;
            tail_q         <= '0;
            busy_q         <= '0;
            done_q         <= '0;
            commit_valid_o <= 1'b0;
        end else begin
            commit_valid_o <= retire;
            if (retire) begin
                busy_q[head_q] <= 1'b0;
                head_q         <= head_q + 1'b1;
            end
            // completion lands on the tag slot
            if (wb_valid_i) begin
                done_q[wb_i.tag] <= 1'b1;
            end
            // alloc last, a freed slot may be reused
            if (alloc_valid_i) begin
                busy_q[tail_q] <= 1'b1;
                done_q[tail_q] <= 1'b0;
                tail_q         <= tail_q + 1'b1;
            end
        end
    end

    // packet storage
    always_ff @(posedge clk_i) begin
        if (wb_valid_i) begin
            entry_q[wb_i.tag] <= wb_i;
        end
    end

    // commit record
    always_ff @(posedge clk_i) begin
        if (retire) begin
            commit_o.tag       <= entry_q[head_q].tag;
            commit_o.rd        <= entry_q[head_q].rd;
            commit_o.value     <= entry_q[head_q].value;
            commit_o.is_branch <= entry_q[head_q].is_branch;
            commit_o.taken     <= entry_q[head_q].taken;
            commit_o.target    <= entry_q[head_q].target;
        end
    end

endmodule

`default_nettype wire

/* rtl/wb_arbiter.sv */
`default_nettype none
`timescale 1ns/100ps

module wb_arbiter (
    input  wire logic                      alu_valid_i,
    input  wire backend_pkg::alu_result_t  alu_res_i,
    output logic                           alu_pop_o,
    input  wire logic                      br_valid_i,
    input  wire backend_pkg::br_result_t   br_res_i,
    output logic                           br_pop_o,
    output logic                           wb_valid_o,
    output backend_pkg::wb_packet_t        wb_o
);

    // alu head always wins, branch only when alu empty
    assign alu_pop_o  = alu_valid_i;
    assign br_pop_o   = br_valid_i && !alu_valid_i;
    assign wb_valid_o = alu_valid_i || br_valid_i;

    // packet mux
    always_comb begin
        wb_o = '0;
        if (alu_valid_i) begin
            wb_o.tag   = alu_res_i.tag;
            wb_o.rd    = alu_res_i.rd;
            wb_o.value = alu_res_i.value;
            // branch fields stay zero
        end else if (br_valid_i) begin
            wb_o.tag       = br_res_i.tag;
            wb_o.rd        = br_res_i.rd;
            wb_o.value     = br_res_i.link;
            wb_o.is_branch = 1'b1;
            wb_o.taken     = br_res_i.taken;
            wb_o.target    = br_res_i.target;
        end
    end

endmodule

`default_nettype wire

/* rtl/result_buffer.sv */
`default_nettype none
`timescale 1ns/100ps

`include "ooo_backend_consts.svh"

module result_buffer #(
    parameter type payload_t = logic
) (
    input  wire logic        clk_i,
    input  wire logic        rst_n_i,
    input  wire logic        push_i,
    input  wire payload_t    push_data_i,
    input  wire logic        pop_i,
    output logic             head_valid_o,
    output payload_t         head_o
);

    // one slot per rob entry, can never fill past that
    payload_t             mem_q [`ROB_DEPTH];
    logic [`TAG_W-1:0]    wr_ptr_q;
    logic [`TAG_W-1:0]    rd_ptr_q;
    logic [`TAG_W:0]      count_q;

    assign head_valid_o = (count_q != '0);
    assign head_o       = mem_q[rd_ptr_q];

    // ------------------------------------------------------------------------
    // pointers and occupancy
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop_i) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({push_i, pop_i})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // storage
    always_ff @(posedge clk_i) begin
        if (push_i) begin
            mem_q[wr_ptr_q] <= push_data_i;
        end
    end

endmodule

`default_nettype wire

/* rtl/branch_unit.sv */
`default_nettype none
`timescale 1ns/100ps

`include "ooo_backend_consts.svh"

module branch_unit (
    input  wire logic                  clk_i,
    input  wire logic                  rst_n_i,
    input  wire logic                  op_valid_i,
    input  wire backend_pkg::br_op_t   op_i,
    output logic                       res_valid_o,
    output backend_pkg::br_result_t    res_o
);

    import isa_pkg::*;

    logic               taken;
    logic [`DATA_W-1:0] link;

    // eq or unsigned less-than
    assign taken = (op_i.cond == BR_EQ) ? (op_i.src_a == op_i.src_b)
                                        : (op_i.src_a < op_i.src_b);
    // fall-through pc doubles as the link value
    assign link  = op_i.pc + `DATA_W'(4);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            res_valid_o <= 1'b0;
        end else begin
            res_valid_o <= op_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (op_valid_i) begin
            res_o.tag    <= op_i.tag;
            res_o.rd     <= op_i.rd;
            res_o.link   <= link;
            res_o.taken  <= taken;
            // not taken goes to pc+4
            res_o.target <= taken ? (op_i.pc + op_i.imm) : link;
        end
    end

endmodule

`default_nettype wire

/* rtl/alu_unit.sv */
`default_nettype none
`timescale 1ns/100ps

module alu_unit (
    input  wire logic                  clk_i,
    input  wire logic                  rst_n_i,
    input  wire logic                  op_valid_i,
    input  wire backend_pkg::alu_op_t  op_i,
    output logic                       res_valid_o,
    output backend_pkg::alu_result_t   res_o
);

    import isa_pkg::*;
    import backend_pkg::*;

    alu_result_t res_d;

    // combinational result, arithmetic wraps
    always_comb begin
        res_d.tag = op_i.tag;
        res_d.rd  = op_i.rd;
        case (op_i.func)
            ALU_ADD: res_d.value = op_i.src_a + op_i.src_b;
            ALU_SUB: res_d.value = op_i.src_a - op_i.src_b;
            ALU_AND: res_d.value = op_i.src_a & op_i.src_b;
            ALU_OR:  res_d.value = op_i.src_a | op_i.src_b;
            ALU_XOR: res_d.value = op_i.src_a ^ op_i.src_b;
            default: res_d.value = '0;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            res_valid_o <= 1'b0;
        end else begin
            res_valid_o <= op_valid_i;
        end
    end

    // result payload
    always_ff @(posedge clk_i) begin
        if (op_valid_i) begin
            res_o <= res_d;
        end
    end

endmodule

`default_nettype wire

/* rtl/issue_stage.sv */
`default_nettype none
`timescale 1ns/100ps

module issue_stage (
    input  wire logic                  clk_i,
    input  wire logic                  rst_n_i,
    input  wire logic                  op_valid_i,
    input  wire isa_pkg::issue_op_t    op_i,
    output logic                       alu_valid_o,
    output backend_pkg::alu_op_t       alu_op_o,
    output logic                       br_valid_o,
    output backend_pkg::br_op_t        br_op_o,
    output logic                       alloc_valid_o
);

    import isa_pkg::*;
    import backend_pkg::*;

    // next tag to hand out, tracks the rob tail
    rob_tag_t tag_q;

    // rob reserves its entry on the accepting edge
    assign alloc_valid_o = op_valid_i;

    // control, one unit valid per accepted op
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            alu_valid_o <= 1'b0;
            br_valid_o  <= 1'b0;
            tag_q       <= '0;
        end else begin
            alu_valid_o <= op_valid_i && (op_i.op_class == OP_ALU);
            br_valid_o  <= op_valid_i && (op_i.op_class == OP_BRANCH);
            if (op_valid_i) begin
                // wraps with the rob depth
                tag_q <= tag_q + 1'b1;
            end
        end
    end

    // payload, both views loaded, only one gets a valid
    always_ff @(posedge clk_i) begin
        if (op_valid_i) begin
            alu_op_o.tag   <= tag_q;
            alu_op_o.func  <= op_i.func;
            alu_op_o.rd    <= op_i.rd;
            alu_op_o.src_a <= op_i.src_a;
            alu_op_o.src_b <= op_i.src_b;
            br_op_o.tag    <= tag_q;
            br_op_o.cond   <= op_i.cond;
            br_op_o.rd     <= op_i.rd;
            br_op_o.src_a  <= op_i.src_a;
            br_op_o.src_b  <= op_i.src_b;
            br_op_o.pc     <= op_i.pc;
            br_op_o.imm    <= op_i.imm;
        end
    end

endmodule

`default_nettype wire

/* rtl/backend_pkg.sv */
`default_nettype none

`include "ooo_backend_consts.svh"

package backend_pkg;

    // index into the reorder buffer
    typedef logic [`TAG_W-1:0] rob_tag_t;

    // ------------------------------------------------------------------------
    // unit side views of an issued op
    // ------------------------------------------------------------------------
    typedef struct packed {
        rob_tag_t                tag;
        isa_pkg::alu_func_t      func;
        logic [`AREG_W-1:0]      rd;
        logic [`DATA_W-1:0]      src_a;
        logic [`DATA_W-1:0]      src_b;
    } alu_op_t;

    typedef struct packed {
        rob_tag_t                tag;
        isa_pkg::br_cond_t       cond;
        logic [`AREG_W-1:0]      rd;
        logic [`DATA_W-1:0]      src_a;
        logic [`DATA_W-1:0]      src_b;
        logic [`DATA_W-1:0]      pc;
        logic [`DATA_W-1:0]      imm;
    } br_op_t;

    // ------------------------------------------------------------------------
    // unit results, writeback and retire
    // ------------------------------------------------------------------------
    typedef struct packed {
        rob_tag_t                tag;
        logic [`AREG_W-1:0]      rd;
        logic [`DATA_W-1:0]      value;
    } alu_result_t;

    // link is pc+4, target is the resolved next pc
    typedef struct packed {
        rob_tag_t                tag;
        logic [`AREG_W-1:0]      rd;
        logic [`DATA_W-1:0]      link;
        logic                    taken;
        logic [`DATA_W-1:0]      target;
    } br_result_t;

    // union of both result kinds
    typedef struct packed {
        rob_tag_t                tag;
        logic [`AREG_W-1:0]      rd;
        logic [`DATA_W-1:0]      value;
        logic                    is_branch;
        logic                    taken;
        logic [`DATA_W-1:0]      target;
    } wb_packet_t;

    typedef struct packed {
        rob_tag_t                tag;
        logic [`AREG_W-1:0]      rd;
        logic [`DATA_W-1:0]      value;
        logic                    is_branch;
        logic                    taken;
        logic [`DATA_W-1:0]      target;
    } commit_rec_t;

endpackage

`default_nettype wire

/* rtl/isa_pkg.sv */
`default_nettype none

`include "ooo_backend_consts.svh"

package isa_pkg;

    // functional unit selection
    typedef enum logic {
        OP_ALU    = 1'b0,
        OP_BRANCH = 1'b1
    } op_class_t;

    // alu operation encodings
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4
    } alu_func_t;

    // branch compare, ltu is unsigned
    typedef enum logic {
        BR_EQ  = 1'b0,
        BR_LTU = 1'b1
    } br_cond_t;

    // decoded op with operand values already read
    typedef struct packed {
        op_class_t               op_class;
        alu_func_t               func;
        br_cond_t                cond;
        logic [`AREG_W-1:0]      rd;
        logic [`DATA_W-1:0]      src_a;
        logic [`DATA_W-1:0]      src_b;
        logic [`DATA_W-1:0]      pc;
        logic [`DATA_W-1:0]      imm;
    } issue_op_t;

endpackage

`default_nettype wire

/* rtl/ooo_backend_consts.svh */
`ifndef OOO_BACKEND_CONSTS_SVH
`define OOO_BACKEND_CONSTS_SVH

// operand and result width
`define DATA_W 32
// architectural destination register number
`define AREG_W 5
// reorder buffer entries, also the initial credit count
`define ROB_DEPTH 8
// log2 of the reorder buffer depth
`define TAG_W 3

`endif
